/* cadr_defines.svh */
// Widths assume a 32-bit microword and a 16-bit spy bus; spy numbers match the debug host
`ifndef CADR_DEFINES_SVH
`define CADR_DEFINES_SVH

//////////////////////////////////////////////////
// Datapath and memory sizes
//////////////////////////////////////////////////
`define CADR_WORD_W   32   // Data and microword width
`define CADR_UADDR_W  10   // 1024 microwords
`define CADR_AADR_W   6    // 64-word A memory
`define CADR_MADR_W   5    // 32-word M memory
`define CADR_SPY_W    16   // Spy data bus
`define CADR_EADR_W   5    // Spy register number
`define CADR_ALUF_W   3    // ALU function field

//////////////////////////////////////////////////
// Spy register numbers
//////////////////////////////////////////////////
`define SPY_DBIRL  5'd0    // Staging word, low half
`define SPY_DBIRH  5'd1    // Staging word, high half
`define SPY_WIMEM  5'd2    // Staged word to microcode store
`define SPY_WAMEM  5'd3    // Staged word to A memory
`define SPY_WMMEM  5'd4    // Staged word to M memory
`define SPY_MODE   5'd5    // Run, step, clear PC
`define SPY_OBL    5'd8    // Output bus, low half
`define SPY_OBH    5'd9    // Output bus, high half
`define SPY_PC     5'd10   // Micro PC
`define SPY_STAT   5'd11   // Bit 0 running

//////////////////////////////////////////////////
// ALU functions, all modulo 2^32
//////////////////////////////////////////////////
`define ALU_ADD   3'd0     // A + M
`define ALU_SUB   3'd1     // M - A
`define ALU_AND   3'd2
`define ALU_IOR   3'd3
`define ALU_XOR   3'd4
`define ALU_SETM  3'd5     // Pass M
`define ALU_SETA  3'd6     // Pass A
`define ALU_INC   3'd7     // A + M + 1

`endif

/* cadr_pkg.sv */
// Microword layout is fixed at 32 bits; bit 31 selects the ALU or the jump view
`include "cadr_defines.svh"

package cadr_pkg;

   // One-hot cycle sequencer state
   typedef enum logic [5:0] {
      ST_RESET  = 6'b000001,
      ST_DECODE = 6'b000010,
      ST_READ   = 6'b000100,
      ST_ALU    = 6'b001000,
      ST_WRITE  = 6'b010000,
      ST_FETCH  = 6'b100000
   } seq_state_t;

   // Jump conditions
   typedef enum logic [1:0] {
      JC_ALWAYS = 2'd0,
      JC_EQ     = 2'd1,        // Taken when A equals M
      JC_NE     = 2'd2,        // Taken when A differs from M
      JC_HALT   = 2'd3         // Stop the machine, PC still advances
   } jcond_t;

   // ALU microword, kind = 0
   typedef struct packed {
      logic                    kind;
      logic [`CADR_ALUF_W-1:0] aluf;
      logic [`CADR_AADR_W-1:0] a_adr;
      logic [`CADR_MADR_W-1:0] m_adr;
      logic                    dest_a;
      logic                    dest_m;
      logic [`CADR_AADR_W-1:0] dest_adr;   // M takes the low bits
      logic [8:0]              spare;
   } uinst_alu_t;

   // Jump microword, kind = 1
   typedef struct packed {
      logic                     kind;
      jcond_t                   cond;
      logic [`CADR_AADR_W-1:0]  a_adr;
      logic [`CADR_MADR_W-1:0]  m_adr;
      logic [`CADR_UADDR_W-1:0] target;
      logic [7:0]               spare;
   } uinst_jump_t;

   // Both views of one microword
   typedef union packed {
      uinst_alu_t  alu;
      uinst_jump_t jmp;
   } uinst_u;

endpackage

/* cadr_seq_fsm.sv */
// Steps and run requests are taken only while halted; a stop request lands at the next fetch
module cadr_seq_fsm
   import cadr_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       run_set,     // Start free running
   input  logic       run_clear,   // Stop after current instruction
   input  logic       step,        // Run exactly one instruction
   input  uinst_u     ir,
   output seq_state_t state,
   output logic       running
);

   seq_state_t state_next;
   logic       step_pend;           // Current run is a single step
   logic       stop_req;            // Stop requested from spy
   logic       halt_jump;
   logic       run_end;

   assign halt_jump = ir.jmp.kind && (ir.jmp.cond == JC_HALT);
   assign run_end   = (state == ST_FETCH) && (halt_jump || step_pend || stop_req);

   //////////////////////////////////////////////////
   // Cycle sequence
   //////////////////////////////////////////////////
   always_comb begin
      case (state)
         ST_RESET:  state_next = ST_DECODE;
         ST_DECODE: state_next = running ? ST_READ : ST_DECODE;   // Idle here when halted
         ST_READ:   state_next = ST_ALU;
         ST_ALU:    state_next = ST_WRITE;
         ST_WRITE:  state_next = ST_FETCH;
         ST_FETCH:  state_next = ST_DECODE;
         default:   state_next = ST_RESET;                         // Recover from bad code
      endcase
   end

   //////////////////////////////////////////////////
   // Run control
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= ST_RESET;
         running   <= 1'b0;
         step_pend <= 1'b0;
         stop_req  <= 1'b0;
      end else begin
         state <= state_next;
         if (run_end) begin                  // Fetch of last instruction
            running   <= 1'b0;
            step_pend <= 1'b0;
            stop_req  <= 1'b0;
         end else if (!running) begin
            if (step) begin                  // Step wins over run
               running   <= 1'b1;
               step_pend <= 1'b1;
            end else if (run_set) begin
               running <= 1'b1;
            end
         end else if (run_clear) begin
            stop_req <= 1'b1;                // Held until fetch
         end
      end
   end

endmodule

/* cadr_upc.sv */
// PC wraps at the control store size; clear requests must already be gated to halted time
`include "cadr_defines.svh"

module cadr_upc
   import cadr_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  seq_state_t               state,
   input  uinst_u                   ir,
   input  logic                     aeqm,       // A equals M from ALU
   input  logic                     pc_clear,   // Spy clear, halted only
   output logic [`CADR_UADDR_W-1:0] pc
);

   logic take_jump;

   //////////////////////////////////////////////////
   // Jump condition
   //////////////////////////////////////////////////
   always_comb begin
      take_jump = 1'b0;
      if (ir.jmp.kind) begin
         case (ir.jmp.cond)
            JC_ALWAYS: take_jump = 1'b1;
            JC_EQ:     take_jump = aeqm;
            JC_NE:     take_jump = !aeqm;
            default:   take_jump = 1'b0;     // Halt just moves on
         endcase
      end
   end

   // Next address is chosen in fetch
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (pc_clear) begin
         pc <= '0;
      end else if (state == ST_FETCH) begin
         if (take_jump)
            pc <= ir.jmp.target;
         else
            pc <= pc + 1'b1;                 // Wraps at 1024
      end
   end

endmodule

/* cadr_imem.sv */
// Store writes arrive from spy only while halted; the IR reloads every decode cycle
`include "cadr_defines.svh"

module cadr_imem
   import cadr_pkg::*;
(
   input  logic                     clk,
   input  seq_state_t               state,
   input  logic [`CADR_UADDR_W-1:0] pc,
   input  logic [`CADR_WORD_W-1:0]  stage_word,   // Word assembled by spy
   input  logic                     wr_imem,      // Spy store strobe
   input  logic [`CADR_UADDR_W-1:0] wr_addr,
   output uinst_u                   ir
);

   localparam int DEPTH = 1 << `CADR_UADDR_W;

   logic [`CADR_WORD_W-1:0] mem [0:DEPTH-1];   // Writable control store

   //////////////////////////////////////////////////
   // Control store write port
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (wr_imem)
         mem[wr_addr] <= stage_word;
   end

   //////////////////////////////////////////////////
   // Instruction register
   //////////////////////////////////////////////////
   // Holds through read, alu, write and fetch
   always_ff @(posedge clk) begin
      if (state == ST_DECODE)
         ir <= mem[pc];
   end

endmodule

/* cadr_regfile.sv */
// Spy writes and ALU writes never overlap since spy writes are only accepted while halted
`include "cadr_defines.svh"

module cadr_regfile
   import cadr_pkg::*;
(
   input  logic                     clk,
   input  seq_state_t               state,
   input  uinst_u                   ir,
   input  logic [`CADR_WORD_W-1:0]  ob_next,      // ALU result
   input  logic [`CADR_WORD_W-1:0]  stage_word,   // Spy staged word
   input  logic                     wr_amem,
   input  logic                     wr_mmem,
   input  logic [`CADR_UADDR_W-1:0] wr_addr,      // Low bits pick the word
   output logic [`CADR_WORD_W-1:0]  a,
   output logic [`CADR_WORD_W-1:0]  m
);

   localparam int A_DEPTH = 1 << `CADR_AADR_W;
   localparam int M_DEPTH = 1 << `CADR_MADR_W;

   logic [`CADR_WORD_W-1:0] amem [0:A_DEPTH-1];
   logic [`CADR_WORD_W-1:0] mmem [0:M_DEPTH-1];
   logic [`CADR_AADR_W-1:0] rd_aadr;
   logic [`CADR_MADR_W-1:0] rd_madr;
   logic                    alu_word;
   logic                    wr_a_alu;
   logic                    wr_m_alu;

   // Source fields sit at different bits in the two views
   assign alu_word = !ir.alu.kind;
   assign rd_aadr  = alu_word ? ir.alu.a_adr : ir.jmp.a_adr;
   assign rd_madr  = alu_word ? ir.alu.m_adr : ir.jmp.m_adr;
   assign wr_a_alu = (state == ST_WRITE) && alu_word && ir.alu.dest_a;
   assign wr_m_alu = (state == ST_WRITE) && alu_word && ir.alu.dest_m;

   //////////////////////////////////////////////////
   // Write ports
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (wr_a_alu)
         amem[ir.alu.dest_adr] <= ob_next;
      else if (wr_amem)
         amem[wr_addr[`CADR_AADR_W-1:0]] <= stage_word;
   end

   always_ff @(posedge clk) begin
      if (wr_m_alu)
         mmem[ir.alu.dest_adr[`CADR_MADR_W-1:0]] <= ob_next;   // Low 5 bits
      else if (wr_mmem)
         mmem[wr_addr[`CADR_MADR_W-1:0]] <= stage_word;
   end

   //////////////////////////////////////////////////
   // Read latches
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (state == ST_READ) begin
         a <= amem[rd_aadr];
         m <= mmem[rd_madr];
      end
   end

endmodule

/* cadr_alu.sv */
// Result and compare are combinational from the A and M latches; only ALU words load ob
`include "cadr_defines.svh"

module cadr_alu
   import cadr_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  seq_state_t              state,
   input  uinst_u                  ir,
   input  logic [`CADR_WORD_W-1:0] a,
   input  logic [`CADR_WORD_W-1:0] m,
   output logic [`CADR_WORD_W-1:0] ob_next,   // To A/M write port
   output logic [`CADR_WORD_W-1:0] ob,        // Output bus register
   output logic                    aeqm
);

   logic load_ob;

   //////////////////////////////////////////////////
   // Function decode
   //////////////////////////////////////////////////
   always_comb begin
      case (ir.alu.aluf)
         `ALU_ADD:  ob_next = a + m;
         `ALU_SUB:  ob_next = m - a;
         `ALU_AND:  ob_next = a & m;
         `ALU_IOR:  ob_next = a | m;
         `ALU_XOR:  ob_next = a ^ m;
         `ALU_SETM: ob_next = m;
         `ALU_SETA: ob_next = a;
         `ALU_INC:  ob_next = a + m + 1'b1;   // Carry in set
         default:   ob_next = m;
      endcase
   end

   assign aeqm = (a == m);                   // Feeds jump conditions

   // Jump words leave ob alone
   assign load_ob = (state == ST_WRITE) && !ir.alu.kind;

   //////////////////////////////////////////////////
   // Output bus register
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset)
         ob <= '0;
      else if (load_ob)
         ob <= ob_next;
   end

endmodule

/* cadr_spy.sv */
// Spy strobes last one cycle; store writes are dropped while running and spy_in carries the address
`include "cadr_defines.svh"

module cadr_spy
   import cadr_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     dbread,
   input  logic                     dbwrite,
   input  logic [`CADR_EADR_W-1:0]  eadr,
   input  logic [`CADR_SPY_W-1:0]   spy_in,
   input  logic                     running,
   input  logic [`CADR_UADDR_W-1:0] pc,
   input  logic [`CADR_WORD_W-1:0]  ob,
   output logic [`CADR_SPY_W-1:0]   spy_out,
   output logic [`CADR_WORD_W-1:0]  stage_word,
   output logic                     wr_imem,
   output logic                     wr_amem,
   output logic                     wr_mmem,
   output logic [`CADR_UADDR_W-1:0] wr_addr,
   output logic                     run_set,
   output logic                     run_clear,
   output logic                     step,
   output logic                     pc_clear
);

   logic                   wr_dbirl;
   logic                   wr_dbirh;
   logic                   mode_wr;
   logic [`CADR_SPY_W-1:0] rd_data;

   //////////////////////////////////////////////////
   // Write decode
   //////////////////////////////////////////////////
   assign wr_dbirl = dbwrite && (eadr == `SPY_DBIRL);
   assign wr_dbirh = dbwrite && (eadr == `SPY_DBIRH);
   assign wr_imem  = dbwrite && (eadr == `SPY_WIMEM) && !running;
   assign wr_amem  = dbwrite && (eadr == `SPY_WAMEM) && !running;
   assign wr_mmem  = dbwrite && (eadr == `SPY_WMMEM) && !running;
   assign wr_addr  = spy_in[`CADR_UADDR_W-1:0];   // Target address

   assign mode_wr   = dbwrite && (eadr == `SPY_MODE);
   assign run_set   = mode_wr && spy_in[0];
   assign step      = mode_wr && spy_in[1];
   assign run_clear = mode_wr && !spy_in[0] && !spy_in[1];   // Mode write with run off
   assign pc_clear  = mode_wr && spy_in[2] && !running;

   // Staging word halves
   always_ff @(posedge clk) begin
      if (wr_dbirl)
         stage_word[`CADR_SPY_W-1:0] <= spy_in;
      if (wr_dbirh)
         stage_word[`CADR_WORD_W-1:`CADR_SPY_W] <= spy_in;
   end

   //////////////////////////////////////////////////
   // Read mux
   //////////////////////////////////////////////////
   always_comb begin
      case (eadr)
         `SPY_DBIRL: rd_data = stage_word[`CADR_SPY_W-1:0];
         `SPY_DBIRH: rd_data = stage_word[`CADR_WORD_W-1:`CADR_SPY_W];
         `SPY_OBL:   rd_data = ob[`CADR_SPY_W-1:0];
         `SPY_OBH:   rd_data = ob[`CADR_WORD_W-1:`CADR_SPY_W];
         `SPY_PC:    rd_data = {{(`CADR_SPY_W-`CADR_UADDR_W){1'b0}}, pc};
         `SPY_STAT:  rd_data = {{(`CADR_SPY_W-1){1'b0}}, running};
         default:    rd_data = '0;                   // Unused numbers read zero
      endcase
   end

   // Holds until the next read strobe
   always_ff @(posedge clk) begin
      if (reset)
         spy_out <= '0;
      else if (dbread)
         spy_out <= rd_data;
   end

endmodule

/* cadr_top.sv */
// Only the spy port reaches the outside; no main memory, no interrupts, no boot PROM
`include "cadr_defines.svh"

module cadr_top
   import cadr_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    dbread,
   input  logic                    dbwrite,
   input  logic [`CADR_EADR_W-1:0] eadr,
   input  logic [`CADR_SPY_W-1:0]  spy_in,
   output logic [`CADR_SPY_W-1:0]  spy_out
);

   seq_state_t               state;
   logic                     running;
   uinst_u                   ir;
   logic [`CADR_UADDR_W-1:0] pc;
   logic [`CADR_WORD_W-1:0]  a;
   logic [`CADR_WORD_W-1:0]  m;
   logic [`CADR_WORD_W-1:0]  ob_next;
   logic [`CADR_WORD_W-1:0]  ob;
   logic                     aeqm;
   logic [`CADR_WORD_W-1:0]  stage_word;
   logic                     wr_imem;
   logic                     wr_amem;
   logic                     wr_mmem;
   logic [`CADR_UADDR_W-1:0] wr_addr;
   logic                     run_set;
   logic                     run_clear;
   logic                     step;
   logic                     pc_clear;

   //////////////////////////////////////////////////
   // Control
   //////////////////////////////////////////////////
   cadr_seq_fsm seq_i (
      .clk       (clk),
      .reset     (reset),
      .run_set   (run_set),
      .run_clear (run_clear),
      .step      (step),
      .ir        (ir),
      .state     (state),
      .running   (running)
   );

   cadr_upc upc_i (
      .clk      (clk),
      .reset    (reset),
      .state    (state),
      .ir       (ir),
      .aeqm     (aeqm),
      .pc_clear (pc_clear),
      .pc       (pc)
   );

   cadr_imem imem_i (
      .clk        (clk),
      .state      (state),
      .pc         (pc),
      .stage_word (stage_word),
      .wr_imem    (wr_imem),
      .wr_addr    (wr_addr),
      .ir         (ir)
   );

   //////////////////////////////////////////////////
   // Datapath
   //////////////////////////////////////////////////
   cadr_regfile regfile_i (
      .clk        (clk),
      .state      (state),
      .ir         (ir),
      .ob_next    (ob_next),
      .stage_word (stage_word),
      .wr_amem    (wr_amem),
      .wr_mmem    (wr_mmem),
      .wr_addr    (wr_addr),
      .a          (a),
      .m          (m)
   );

   cadr_alu alu_i (
      .clk     (clk),
      .reset   (reset),
      .state   (state),
      .ir      (ir),
      .a       (a),
      .m       (m),
      .ob_next (ob_next),
      .ob      (ob),
      .aeqm    (aeqm)
   );

   //////////////////////////////////////////////////
   // Debug port
   //////////////////////////////////////////////////
   cadr_spy spy_i (
      .clk        (clk),
      .reset      (reset),
      .dbread     (dbread),
      .dbwrite    (dbwrite),
      .eadr       (eadr),
      .spy_in     (spy_in),
      .running    (running),
      .pc         (pc),
      .ob         (ob),
      .spy_out    (spy_out),
      .stage_word (stage_word),
      .wr_imem    (wr_imem),
      .wr_amem    (wr_amem),
      .wr_mmem    (wr_mmem),
      .wr_addr    (wr_addr),
      .run_set    (run_set),
      .run_clear  (run_clear),
      .step       (step),
      .pc_clear   (pc_clear)
   );

endmodule

/* cadr_tb.sv */
// Drives only the spy port; A and M are fully loaded before any microword reads them
`include "cadr_defines.svh"

module cadr_tb
   import cadr_pkg::*;
();

   localparam int N_ALU      = 16;                   // Stepped ALU words
   localparam int N_CHAIN    = 12;                   // Stepped words feeding each other
   localparam int N_JUMP     = 16;                   // Stepped jump words
   localparam int N_PROG     = 20;                   // Run-mode words before the halt
   localparam int MAX_CYCLES = (N_ALU + N_CHAIN + N_JUMP + N_PROG + 1) * 200 + 4000;

   logic                     clk;
   logic                     reset;
   logic                     dbread;
   logic                     dbwrite;
   logic [`CADR_EADR_W-1:0]  eadr;
   logic [`CADR_SPY_W-1:0]   spy_in;
   logic [`CADR_SPY_W-1:0]   spy_out;

   logic [`CADR_WORD_W-1:0]  imem_m [0:(1 << `CADR_UADDR_W)-1];   // Reference control store
   logic [`CADR_WORD_W-1:0]  amem_m [0:(1 << `CADR_AADR_W)-1];
   logic [`CADR_WORD_W-1:0]  mmem_m [0:(1 << `CADR_MADR_W)-1];
   logic [`CADR_UADDR_W-1:0] pc_m;
   logic [`CADR_WORD_W-1:0]  ob_m;
   logic                     running_m;
   integer                   seed;
   integer                   cycles = 0;

   cadr_top dut_i (
      .clk     (clk),
      .reset   (reset),
      .dbread  (dbread),
      .dbwrite (dbwrite),
      .eadr    (eadr),
      .spy_in  (spy_in),
      .spy_out (spy_out)
   );

   always #2 clk = ~clk;                            // Period 4

   //////////////////////////////////////////////////
   // Failure handling and compares
   //////////////////////////////////////////////////
   task automatic abort_run();
      $display("Some tests failed");
      $fatal(1);
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the DUT did not finish its work within %0d cycles", MAX_CYCLES);
         abort_run();
      end
   end

   task automatic check_word(input logic [`CADR_WORD_W-1:0] got,
                             input logic [`CADR_WORD_W-1:0] exp, input string what);
      if (got !== exp) begin
         $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_pc(input logic [`CADR_UADDR_W-1:0] got,
                           input logic [`CADR_UADDR_W-1:0] exp, input string what);
      if (got !== exp) begin
         $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_stat(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   //////////////////////////////////////////////////
   // Spy port access, entered on a falling edge
   //////////////////////////////////////////////////
   task automatic spy_write(input logic [`CADR_EADR_W-1:0] reg_num,
                            input logic [`CADR_SPY_W-1:0] data);
      dbwrite = 1'b1;
      eadr    = reg_num;
      spy_in  = data;
      @(negedge clk);                               // Strobe lasts one cycle
      dbwrite = 1'b0;
   endtask

   task automatic spy_read(input logic [`CADR_EADR_W-1:0] reg_num,
                           output logic [`CADR_SPY_W-1:0] data);
      dbread = 1'b1;
      eadr   = reg_num;
      @(negedge clk);
      dbread = 1'b0;
      data   = spy_out;                             // Stable since the rising edge
   endtask

   task automatic load_word(input logic [`CADR_EADR_W-1:0] reg_num,
                            input logic [`CADR_SPY_W-1:0] addr,
                            input logic [`CADR_WORD_W-1:0] word);
      spy_write(`SPY_DBIRL, word[15:0]);
      spy_write(`SPY_DBIRH, word[31:16]);
      spy_write(reg_num, addr);                     // spy_in carries the address
   endtask

   task automatic read_ob(output logic [`CADR_WORD_W-1:0] word);
      logic [`CADR_SPY_W-1:0] lo;
      logic [`CADR_SPY_W-1:0] hi;
      spy_read(`SPY_OBL, lo);
      spy_read(`SPY_OBH, hi);
      word = {hi, lo};
   endtask

   task automatic read_pc(output logic [`CADR_UADDR_W-1:0] pc_val);
      logic [`CADR_SPY_W-1:0] v;
      spy_read(`SPY_PC, v);
      pc_val = v[`CADR_UADDR_W-1:0];
   endtask

   // Poll the status word until the machine stops
   task automatic wait_halt();
      logic [`CADR_SPY_W-1:0] stat;
      stat = 16'h0001;
      while (stat[0])
         spy_read(`SPY_STAT, stat);
   endtask

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////
   function automatic logic [31:0] model_alu(input logic [2:0] f, input logic [31:0] a,
                                             input logic [31:0] m);
      case (f)
         `ALU_ADD:  return a + m;
         `ALU_SUB:  return m - a;
         `ALU_AND:  return a & m;
         `ALU_IOR:  return a | m;
         `ALU_XOR:  return a ^ m;
         `ALU_SETM: return m;
         `ALU_SETA: return a;
         default:   return a + m + 32'd1;           // ALU_INC
      endcase
   endfunction

   task automatic model_exec(input uinst_u w);
      logic [31:0] a;
      logic [31:0] m;
      logic        taken;
      if (!w.alu.kind) begin
         a    = amem_m[w.alu.a_adr];
         m    = mmem_m[w.alu.m_adr];
         ob_m = model_alu(w.alu.aluf, a, m);
         if (w.alu.dest_a)
            amem_m[w.alu.dest_adr] = ob_m;
         if (w.alu.dest_m)
            mmem_m[w.alu.dest_adr[`CADR_MADR_W-1:0]] = ob_m;   // Low 5 bits
         pc_m = pc_m + 1'b1;
      end else begin
         a     = amem_m[w.jmp.a_adr];
         m     = mmem_m[w.jmp.m_adr];
         taken = (w.jmp.cond == JC_ALWAYS) || (w.jmp.cond == JC_EQ && a == m) ||
                 (w.jmp.cond == JC_NE && a != m);
         if (w.jmp.cond == JC_HALT)
            running_m = 1'b0;
         pc_m = taken ? w.jmp.target : pc_m + 1'b1;  // Wraps at 1024
      end
   endtask

   function automatic uinst_u rand_alu(input logic da, input logic dm);
      uinst_u w;
      w             = $random(seed);                // Random op and addresses
      w.alu.kind    = 1'b0;
      w.alu.dest_a  = da;
      w.alu.dest_m  = dm;
      w.alu.spare   = '0;
      return w;
   endfunction

   function automatic uinst_u rand_jump();
      uinst_u w;
      w           = $random(seed);
      w.jmp.kind  = 1'b1;
      w.jmp.spare = '0;
      return w;
   endfunction

   // Store at pc, single step, then compare pc and ob
   task automatic exec_step(input uinst_u w);
      logic [`CADR_UADDR_W-1:0] pc_dut;
      logic [`CADR_WORD_W-1:0]  ob_dut;
      load_word(`SPY_WIMEM, pc_m, w);
      imem_m[pc_m] = w;
      model_exec(w);
      spy_write(`SPY_MODE, 16'h0002);
      wait_halt();
      read_pc(pc_dut);
      check_pc(pc_dut, pc_m, "pc after step");
      read_ob(ob_dut);
      check_word(ob_dut, ob_m, "ob after step");
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////
   initial begin
      logic [`CADR_SPY_W-1:0]   v;
      logic [`CADR_UADDR_W-1:0] pc_dut;
      logic [`CADR_WORD_W-1:0]  ob_dut;
      logic [`CADR_AADR_W-1:0]  prev;
      uinst_u                   w;
      integer                   r;
      seed      = 32'h13c3;
      clk       = 1'b0;
      reset     = 1'b1;
      dbread    = 1'b0;
      dbwrite   = 1'b0;
      eadr      = '0;
      spy_in    = '0;
      pc_m      = '0;
      ob_m      = '0;
      running_m = 1'b0;
      repeat (16) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      // Reset state
      spy_read(`SPY_STAT, v);
      check_stat(v[0], 1'b0, "running after reset");
      read_pc(pc_dut);
      check_pc(pc_dut, '0, "pc after reset");
      read_ob(ob_dut);
      check_word(ob_dut, '0, "ob after reset");

      for (int i = 0; i < (1 << `CADR_AADR_W); i++) begin
         amem_m[i] = $random(seed);
         load_word(`SPY_WAMEM, i, amem_m[i]);
      end
      for (int i = 0; i < (1 << `CADR_MADR_W); i++) begin
         mmem_m[i] = $random(seed);
         load_word(`SPY_WMMEM, i, mmem_m[i]);
      end

      for (int i = 0; i < N_ALU; i++)
         exec_step(rand_alu(1'b0, 1'b0));

      // Each word reads the previous destination
      for (int i = 0; i < N_CHAIN; i++) begin
         w = rand_alu(1'b1, 1'b1);
         if (i > 0 && i % 2 == 1)
            w.alu.a_adr = prev;
         else if (i > 0)
            w.alu.m_adr = prev[`CADR_MADR_W-1:0];
         prev = w.alu.dest_adr;
         exec_step(w);
      end

      for (int i = 0; i < N_JUMP; i++) begin
         w = rand_jump();
         r = $random(seed);
         if (r[0]) begin                            // Force A equal to M
            amem_m[w.jmp.a_adr] = mmem_m[w.jmp.m_adr];
            load_word(`SPY_WAMEM, w.jmp.a_adr, amem_m[w.jmp.a_adr]);
         end
         exec_step(w);
      end

      // Run mode from address zero
      spy_write(`SPY_MODE, 16'h0004);
      pc_m = '0;
      read_pc(pc_dut);
      check_pc(pc_dut, '0, "pc after clear");
      for (int i = 0; i < N_PROG; i++) begin
         r = $random(seed);
         imem_m[i] = rand_alu(r[0], r[1]);
         load_word(`SPY_WIMEM, i, imem_m[i]);
      end
      w          = rand_jump();
      w.jmp.cond = JC_HALT;
      imem_m[N_PROG] = w;
      load_word(`SPY_WIMEM, N_PROG, w);
      running_m = 1'b1;
      while (running_m)
         model_exec(imem_m[pc_m]);
      spy_write(`SPY_MODE, 16'h0001);
      spy_read(`SPY_STAT, v);
      check_stat(v[0], 1'b1, "running after run start");
      wait_halt();
      read_pc(pc_dut);
      check_pc(pc_dut, pc_m, "pc after halt");
      read_ob(ob_dut);
      check_word(ob_dut, ob_m, "ob after halt");
      spy_write(`SPY_MODE, 16'h0004);
      read_pc(pc_dut);
      check_pc(pc_dut, '0, "pc after clear");

      $display("All tests passed");
      $finish;
   end

endmodule

/* list.f */
+incdir+.
cadr_pkg.sv
cadr_seq_fsm.sv
cadr_upc.sv
cadr_imem.sv
cadr_regfile.sv
cadr_alu.sv
cadr_spy.sv
cadr_top.sv
cadr_tb.sv
